/* Bender.yml */
package:
  name: add_sub_core

sources:
  - source/ooo_pkg.sv
  - source/issue_stage.sv
  - source/add_sub_station.sv
  - source/cdb_writeback.sv
  - source/add_sub_core.sv
  - target: test
    files:
      - bench/add_sub_core_sva.sv
      - bench/add_sub_checker.sv
      - bench/add_sub_core_tb.sv

/* bench/add_sub_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module add_sub_checker import ooo_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  inst_t                inst,
	input  logic                 inst_valid,
	input  logic                 inst_ready,
	input  logic [TAG_WIDTH-1:0] issue_tag,
	input  result_t              result,
	input  logic                 result_valid,
	input  logic                 result_ready,
	input  logic                 end_check,
	output int                   mismatch_errors,
	output int                   protocol_errors,
	output int                   in_flight,
	output int                   checked
);

	localparam int TAGS = 2 ** TAG_WIDTH;

	logic [DATA_WIDTH-1:0] model_reg   [REG_COUNT];   // in-order architectural state
	logic [DATA_WIDTH-1:0] expect_data [TAGS];
	logic [REG_WIDTH-1:0]  expect_rd   [TAGS];
	logic [TAGS-1:0]       pending;
	int                    mis_cnt;
	int                    proto_cnt;
	int                    done_cnt;
	logic                  end_seen;

	function automatic logic [DATA_WIDTH-1:0] expected_value(inst_t i,
			logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
		logic [DATA_WIDTH-1:0] imm;
		imm = {{(DATA_WIDTH - IMM_WIDTH){i.imm[IMM_WIDTH-1]}}, i.imm};
		case (i.op)
			OP_ADD:     return a + b;
			OP_SUB:     return a - b;
			OP_ADDI:    return a + imm;
			OP_SUBI:    return a - imm;
			OP_ADD_SL2: return a + b * 4;
			OP_SUB_SL2: return a - b * 4;
			default:    return '0;
		endcase
	endfunction

	task check_result();
		if (!pending[result.tag]) begin
			$display("unexpected result with tag %0d, nothing in flight under it", result.tag);
			proto_cnt++;
		end else begin
			if (result.rd !== expect_rd[result.tag] || result.data !== expect_data[result.tag]) begin
				$display("[FAIL] %0t tag %0d: got r%0d = %h, expected r%0d = %h", $time,
					result.tag, result.rd, result.data,
					expect_rd[result.tag], expect_data[result.tag]);
				mis_cnt++;
			end
			pending[result.tag] = 1'b0;
			done_cnt++;
		end
	endtask

	task record_issue();
		if (pending[issue_tag]) begin
			$display("tag %0d handed out again while still in flight", issue_tag);
			proto_cnt++;
		end
		expect_data[issue_tag] = expected_value(inst, model_reg[inst.rs_a], model_reg[inst.rs_b]);
		expect_rd[issue_tag]   = inst.rd;
		model_reg[inst.rd]     = expect_data[issue_tag];
		pending[issue_tag]     = 1'b1;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				model_reg[r] = '0;
			end
			pending   = '0;
			mis_cnt   = 0;
			proto_cnt = 0;
			done_cnt  = 0;
			end_seen  = 1'b0;
		end else begin
			if (result_valid && result_ready) check_result();   // before reuse of the tag
			if (inst_valid && inst_ready) record_issue();
			if (end_check && !end_seen) begin
				end_seen = 1'b1;
				if (pending != '0) begin
					$display("%0d accepted instructions never returned a result",
						$countones(pending));
					proto_cnt++;
				end
			end
		end
		mismatch_errors <= mis_cnt;
		protocol_errors <= proto_cnt;
		in_flight       <= $countones(pending);
		checked         <= done_cnt;
	end

endmodule

`default_nettype wire

/* bench/add_sub_core_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module add_sub_core_sva import ooo_pkg::*; (
	input logic    clk,
	input logic    reset,
	input inst_t   inst,
	input logic    inst_valid,
	input logic    inst_ready,
	input result_t result,
	input logic    result_valid,
	input logic    result_ready
);

	int assert_failures = 0;

	// stalled result holds still
	assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result))
	else begin
		assert_failures++;
		$error("result or result_valid changed while result_ready was low");
	end

	assert property (@(posedge clk) disable iff (reset)
		inst_valid && !inst_ready |=> inst_valid && $stable(inst))
	else begin
		assert_failures++;
		$error("instruction changed while stalled");
	end

	assert property (@(posedge clk) reset |=> !result_valid)
	else begin
		assert_failures++;
		$error("result_valid high right after reset");
	end

endmodule

bind add_sub_core add_sub_core_sva sva_i (.*);

`default_nettype wire

/* bench/add_sub_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module add_sub_core_tb import ooo_pkg::*; ();

	localparam int NUM_INSTS = 400;
	localparam int TIMEOUT   = NUM_INSTS * 40 + 100;
	localparam int DRAIN_MAX = 500;

	logic                 clk;
	logic                 reset;
	inst_t                inst;
	logic                 inst_valid;
	logic                 inst_ready;
	logic [TAG_WIDTH-1:0] issue_tag;
	result_t              result;
	logic                 result_valid;
	logic                 result_ready;
	logic                 end_check;
	int                   mismatch_errors;
	int                   protocol_errors;
	int                   in_flight;
	int                   checked;
	integer               seed;
	int                   sent;
	int                   drain;
	int                   stall;
	int                   cycles;
	int                   errors;

	add_sub_core dut_i (.*);

	add_sub_checker checker_i (.*);

	function automatic inst_t random_inst();
		inst_t i;
		i.op   = op_e'($unsigned($random(seed)) % 6);
		i.rd   = REG_WIDTH'($random(seed) & 3);   // few registers, many dependences
		i.rs_a = REG_WIDTH'($random(seed) & 3);
		i.rs_b = REG_WIDTH'($random(seed) & 3);
		i.imm  = IMM_WIDTH'($random(seed));
		return i;
	endfunction

	// result_ready low in short random bursts
	task pace_result_ready();
		if (stall > 0) begin
			stall = stall - 1;
			result_ready <= 1'b0;
		end else if (($random(seed) & 7) == 0) begin
			stall = $random(seed) & 7;
			result_ready <= 1'b0;
		end else begin
			result_ready <= 1'b1;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", TIMEOUT);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		seed         = 32'h5bb4;
		reset        = 1'b1;
		inst         = '0;
		inst_valid   = 1'b0;
		result_ready = 1'b0;
		end_check    = 1'b0;
		sent         = 0;
		stall        = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		while (sent < NUM_INSTS) begin
			@(posedge clk);
			if (inst_valid && inst_ready) sent++;
			pace_result_ready();
			if (!inst_valid || inst_ready) begin
				if (sent < NUM_INSTS && ($random(seed) & 3) != 0) begin
					inst       <= random_inst();
					inst_valid <= 1'b1;
				end else begin
					inst_valid <= 1'b0;   // gap
				end
			end
		end

		drain = 0;
		do begin
			@(posedge clk);
			pace_result_ready();
			drain++;
		end while (in_flight != 0 && drain < DRAIN_MAX);

		end_check <= 1'b1;
		repeat (2) @(posedge clk);
		errors = mismatch_errors + protocol_errors + dut_i.sva_i.assert_failures;
		$display("%0d results checked, %0d mismatches, %0d protocol errors, %0d assertion failures",
			checked, mismatch_errors, protocol_errors, dut_i.sva_i.assert_failures);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/add_sub_core.sv */
`timescale 1ns/10ps
`default_nettype none

module add_sub_core import ooo_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  inst_t                inst,
	input  logic                 inst_valid,
	output logic                 inst_ready,
	output logic [TAG_WIDTH-1:0] issue_tag,
	output result_t              result,
	output logic                 result_valid,
	input  logic                 result_ready
);

	rs_entry_t            entry;
	logic [REG_WIDTH-1:0] entry_rd;
	logic                 entry_ready;
	result_t              exec;
	logic                 exec_valid;
	logic                 exec_ready;
	cdb_t                 cdb;   // watched by issue and station

	issue_stage issue_i (
		.clk         (clk),
		.reset       (reset),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.inst_ready  (inst_ready),
		.issue_tag   (issue_tag),
		.entry       (entry),
		.entry_rd    (entry_rd),
		.entry_ready (entry_ready),
		.cdb         (cdb)
	);

	add_sub_station station_i (
		.clk         (clk),
		.reset       (reset),
		.entry       (entry),
		.entry_rd    (entry_rd),
		.entry_ready (entry_ready),
		.cdb         (cdb),
		.exec        (exec),
		.exec_valid  (exec_valid),
		.exec_ready  (exec_ready)
	);

	cdb_writeback writeback_i (
		.clk          (clk),
		.reset        (reset),
		.exec         (exec),
		.exec_valid   (exec_valid),
		.exec_ready   (exec_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.cdb          (cdb)
	);

endmodule

`default_nettype wire

/* source/add_sub_station.sv */
`timescale 1ns/10ps
`default_nettype none

module add_sub_station import ooo_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  rs_entry_t            entry,
	input  logic [REG_WIDTH-1:0] entry_rd,
	output logic                 entry_ready,
	input  cdb_t                 cdb,
	output result_t              exec,
	output logic                 exec_valid,
	input  logic                 exec_ready
);

	localparam int SLOTS = 2;

	rs_entry_t            slot      [SLOTS];   // filled from 0, compacted
	logic [REG_WIDTH-1:0] slot_rd   [SLOTS];
	rs_entry_t            slot_woke [SLOTS];
	rs_entry_t            next_slot [SLOTS];
	logic [REG_WIDTH-1:0] next_rd   [SLOTS];

	logic [SLOTS-1:0] slot_ready;
	logic             exec_free;
	logic             dispatch;
	logic             pick;
	rs_entry_t        incoming;
	rs_entry_t        chosen;

	for (genvar j = 0; j < SLOTS; j++) begin : g_slot
		assign slot_woke[j]  = wake_entry(slot[j], cdb);
		assign slot_ready[j] = slot[j].valid && slot[j].opd_a.ready && slot[j].opd_b.ready;
	end

	assign exec_free   = !exec_valid || exec_ready;
	assign dispatch    = exec_free && |slot_ready;
	assign pick        = !slot_ready[0];   // oldest ready first
	assign chosen      = slot[pick];
	assign entry_ready = !slot[SLOTS-1].valid || dispatch;

	always_comb begin
		incoming       = wake_entry(entry, cdb);
		incoming.valid = entry.valid && entry_ready;

		next_slot[0] = slot_woke[0];
		next_rd[0]   = slot_rd[0];
		next_slot[1] = slot_woke[1];
		next_rd[1]   = slot_rd[1];
		if (dispatch) begin
			if (!pick) begin
				next_slot[0] = slot_woke[1];
				next_rd[0]   = slot_rd[1];
			end
			next_slot[1].valid = 1'b0;
		end

		// new entry goes behind the survivors
		if (!next_slot[0].valid) begin
			next_slot[0] = incoming;
			next_rd[0]   = entry_rd;
		end else if (!next_slot[1].valid) begin
			next_slot[1] = incoming;
			next_rd[1]   = entry_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int j = 0; j < SLOTS; j++) begin
				slot[j].valid <= 1'b0;
			end
		end else begin
			for (int j = 0; j < SLOTS; j++) begin
				slot[j]    <= next_slot[j];
				slot_rd[j] <= next_rd[j];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exec_valid <= 1'b0;
		end else if (dispatch) begin
			exec_valid <= 1'b1;
		end else if (exec_ready) begin
			exec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			exec.tag <= chosen.tag;
			exec.rd  <= slot_rd[pick];
			if (chosen.subtract) begin
				exec.data <= chosen.opd_a.data - chosen.opd_b.data;
			end else begin
				exec.data <= chosen.opd_a.data + chosen.opd_b.data;
			end
		end
	end

endmodule

`default_nettype wire

/* source/cdb_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_writeback import ooo_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  result_t exec,
	input  logic    exec_valid,
	output logic    exec_ready,
	output result_t result,
	output logic    result_valid,
	input  logic    result_ready,
	output cdb_t    cdb
);

	logic load;
	logic transfer;

	assign transfer   = result_valid && result_ready;
	assign exec_ready = !result_valid || result_ready;
	assign load       = exec_valid && exec_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else if (exec_ready) begin
			result_valid <= exec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			result <= exec;
		end
	end

	// broadcast only when the stream takes the result
	always_comb begin
		cdb.valid = transfer;
		cdb.tag   = result.tag;
		cdb.data  = result.data;
	end

endmodule

`default_nettype wire

/* source/issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_stage import ooo_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  inst_t                inst,
	input  logic                 inst_valid,
	output logic                 inst_ready,
	output logic [TAG_WIDTH-1:0] issue_tag,
	output rs_entry_t            entry,
	output logic [REG_WIDTH-1:0] entry_rd,
	input  logic                 entry_ready,
	input  cdb_t                 cdb
);

	logic [DATA_WIDTH-1:0] reg_data [REG_COUNT];
	logic [TAG_WIDTH-1:0]  reg_tag  [REG_COUNT];
	logic [REG_COUNT-1:0]  reg_busy;
	logic [TAG_WIDTH-1:0]  next_tag;

	logic                  accept;
	logic                  subtract;
	logic                  shift_b;
	logic                  use_imm;
	logic [DATA_WIDTH-1:0] imm_ext;
	operand_t              opd_a;
	operand_t              opd_b;
	rs_entry_t             new_entry;

	assign inst_ready = !entry.valid || entry_ready;
	assign accept     = inst_valid && inst_ready;
	assign issue_tag  = next_tag;
	assign imm_ext    = DATA_WIDTH'($signed(inst.imm));

	always_comb begin
		subtract = 1'b0;
		shift_b  = 1'b0;
		use_imm  = 1'b0;
		case (inst.op)
			OP_SUB:     subtract = 1'b1;
			OP_ADDI:    use_imm  = 1'b1;
			OP_SUBI: begin
				subtract = 1'b1;
				use_imm  = 1'b1;
			end
			OP_ADD_SL2: shift_b  = 1'b1;
			OP_SUB_SL2: begin
				subtract = 1'b1;
				shift_b  = 1'b1;
			end
			default: ;
		endcase
	end

	// register read, with bypass from a broadcast in this cycle
	always_comb begin
		opd_a.ready = !reg_busy[inst.rs_a];
		opd_a.tag   = reg_tag[inst.rs_a];
		opd_a.data  = reg_data[inst.rs_a];
		opd_a       = wake(opd_a, cdb, 1'b0);

		if (use_imm) begin
			opd_b.ready = 1'b1;
			opd_b.tag   = '0;
			opd_b.data  = imm_ext;
		end else begin
			opd_b.ready = !reg_busy[inst.rs_b];
			opd_b.tag   = reg_tag[inst.rs_b];
			opd_b.data  = shift_b ? reg_data[inst.rs_b] << 2 : reg_data[inst.rs_b];
			opd_b       = wake(opd_b, cdb, shift_b);
		end

		new_entry.valid    = 1'b1;
		new_entry.tag      = next_tag;
		new_entry.subtract = subtract;
		new_entry.shift_b  = shift_b;
		new_entry.opd_a    = opd_a;
		new_entry.opd_b    = opd_b;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_busy    <= '0;
			next_tag    <= '0;
			entry.valid <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++) begin
				reg_data[i] <= '0;
			end
		end else begin
			// only the latest writer clears busy
			if (cdb.valid) begin
				for (int i = 0; i < REG_COUNT; i++) begin
					if (reg_busy[i] && reg_tag[i] == cdb.tag) begin
						reg_busy[i] <= 1'b0;
						reg_data[i] <= cdb.data;
					end
				end
			end

			if (accept) begin
				reg_busy[inst.rd] <= 1'b1;   // overrides a clear above
				reg_tag[inst.rd]  <= next_tag;
				next_tag          <= next_tag + 1'b1;
				entry             <= new_entry;
				entry_rd          <= inst.rd;
			end else if (entry_ready) begin
				entry.valid <= 1'b0;
			end else begin
				entry <= wake_entry(entry, cdb);   // held entry keeps snooping
			end
		end
	end

endmodule

`default_nettype wire

/* source/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int REG_COUNT  = 8;
	localparam int REG_WIDTH  = 3;
	localparam int TAG_WIDTH  = 4;   // 16 tags, at most 5 in flight
	localparam int IMM_WIDTH  = 16;

	typedef enum logic [2:0] {
		OP_ADD     = 3'd0,
		OP_SUB     = 3'd1,
		OP_ADDI    = 3'd2,
		OP_SUBI    = 3'd3,
		OP_ADD_SL2 = 3'd4,
		OP_SUB_SL2 = 3'd5
	} op_e;

	typedef struct packed {
		op_e                  op;
		logic [REG_WIDTH-1:0] rd;
		logic [REG_WIDTH-1:0] rs_a;
		logic [REG_WIDTH-1:0] rs_b;
		logic [IMM_WIDTH-1:0] imm;
	} inst_t;

	// data valid when ready, otherwise tag names the producer
	typedef struct packed {
		logic                  ready;
		logic [TAG_WIDTH-1:0]  tag;
		logic [DATA_WIDTH-1:0] data;
	} operand_t;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
		logic                 subtract;
		logic                 shift_b;
		operand_t             opd_a;
		operand_t             opd_b;
	} rs_entry_t;

	typedef struct packed {
		logic [TAG_WIDTH-1:0]  tag;
		logic [REG_WIDTH-1:0]  rd;
		logic [DATA_WIDTH-1:0] data;
	} result_t;

	typedef struct packed {
		logic                  valid;
		logic [TAG_WIDTH-1:0]  tag;
		logic [DATA_WIDTH-1:0] data;
	} cdb_t;

	// capture a waiting operand from the cdb
	function automatic operand_t wake(operand_t opd, cdb_t cdb, logic shift);
		operand_t w;
		w = opd;
		if (!opd.ready && cdb.valid && cdb.tag == opd.tag) begin
			w.ready = 1'b1;
			w.data  = shift ? cdb.data << 2 : cdb.data;
		end
		return w;
	endfunction

	function automatic rs_entry_t wake_entry(rs_entry_t e, cdb_t cdb);
		rs_entry_t w;
		w       = e;
		w.opd_a = wake(e.opd_a, cdb, 1'b0);
		w.opd_b = wake(e.opd_b, cdb, e.shift_b);
		return w;
	endfunction

endpackage

`default_nettype wire

/* vlog.f */
source/ooo_pkg.sv
source/issue_stage.sv
source/add_sub_station.sv
source/cdb_writeback.sv
source/add_sub_core.sv
bench/add_sub_core_sva.sv
bench/add_sub_checker.sv
bench/add_sub_core_tb.sv
